// File: logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    parameter int XLEN = 32;

    parameter logic [6:0] OPCODE_OP     = 7'b0110011;
    parameter logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPCODE_LUI    = 7'b0110111;
    parameter logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    parameter logic [6:0] OPCODE_JAL    = 7'b1101111;
    parameter logic [6:0] OPCODE_JALR   = 7'b1100111;
    parameter logic [6:0] OPCODE_BRANCH = 7'b1100011;

    parameter logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef enum logic [2:0] {
        ALU,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BRANCH,
        MUL,
        DIV
    } op_class_e;

    typedef struct packed {
        op_class_e       op_class;
        logic [2:0]      funct3;
        logic            alt;
        logic            use_imm;
        logic [4:0]      rd;
        logic            rd_write;
        logic [XLEN-1:0] imm;
        logic            illegal;
    } decoded_t;

    // Unsigned product of two magnitudes
    typedef logic [2*XLEN-1:0] mul_result_t;

    typedef struct packed {
        logic [XLEN-1:0] quotient;
        logic [XLEN-1:0] remainder;
        logic            by_zero;
    } div_result_t;

endpackage

`default_nettype wire

// File: logic/iter_op_if.sv
`timescale 1ns/1ps
`default_nettype none

interface iter_op_if #(
    parameter int  WIDTH    = 32,
    parameter type result_t = logic [WIDTH-1:0]
);
    logic             req_valid;
    logic             req_ready;
    logic [WIDTH-1:0] operand_a;
    logic [WIDTH-1:0] operand_b;
    logic             resp_valid;
    result_t          result;

    modport requester (
        output req_valid, operand_a, operand_b,
        input  req_ready, resp_valid, result
    );

    modport unit (
        input  req_valid, operand_a, operand_b,
        output req_ready, resp_valid, result
    );
endinterface

`default_nettype wire

// File: logic/exec_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module exec_decoder (
    input  logic [exec_pkg::XLEN-1:0] instr,
    output exec_pkg::decoded_t        decoded
);
    import exec_pkg::*;

    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;
    logic            writes_rd;

    assign opcode = instr[6:0];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        decoded.op_class = ALU;
        decoded.funct3   = instr[14:12];
        decoded.alt      = instr[30];
        decoded.use_imm  = 1'b0;
        decoded.rd       = instr[11:7];
        decoded.imm      = imm_i;
        decoded.illegal  = 1'b0;
        writes_rd        = 1'b1;
        case (opcode)
            OPCODE_OP: begin
                if (funct7 == FUNCT7_MULDIV) begin
                    decoded.op_class = instr[14] ? DIV : MUL;
                end else if (funct7 != 7'h00 && funct7 != 7'h20) begin
                    decoded.illegal = 1'b1;
                end
            end
            OPCODE_OP_IMM: decoded.use_imm = 1'b1;
            OPCODE_LUI: begin
                decoded.op_class = LUI;
                decoded.imm      = imm_u;
            end
            OPCODE_AUIPC: begin
                decoded.op_class = AUIPC;
                decoded.imm      = imm_u;
            end
            OPCODE_JAL: begin
                decoded.op_class = JAL;
                decoded.imm      = imm_j;
            end
            OPCODE_JALR: begin
                decoded.op_class = JALR;
                decoded.illegal  = instr[14:12] != 3'b000;
            end
            OPCODE_BRANCH: begin
                decoded.op_class = BRANCH;
                decoded.imm      = imm_b;
                decoded.illegal  = instr[14:13] == 2'b01;
                writes_rd        = 1'b0;
            end
            default: begin
                decoded.illegal = 1'b1;
                writes_rd       = 1'b0;
            end
        endcase
        decoded.rd_write = writes_rd && (instr[11:7] != 5'd0);
    end

endmodule

`default_nettype wire

// File: logic/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  exec_pkg::decoded_t        decoded,
    input  logic [exec_pkg::XLEN-1:0] rs1,
    input  logic [exec_pkg::XLEN-1:0] rs2,
    output logic [exec_pkg::XLEN-1:0] result,
    output logic                      branch_taken,
    output logic                      illegal
);
    import exec_pkg::*;

    logic [XLEN-1:0] opb;
    logic [4:0]      shamt;
    logic            alt_bad;

    assign opb   = decoded.use_imm ? decoded.imm : rs2;
    assign shamt = opb[4:0];

    always_comb begin
        case (decoded.funct3)
            3'b000: begin
                // Bit 30 belongs to the immediate for ADDI
                if (decoded.alt && !decoded.use_imm)
                    result = rs1 - opb;
                else
                    result = rs1 + opb;
            end
            3'b001: result = rs1 << shamt;
            3'b010: result = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(opb)};
            3'b011: result = {{(XLEN-1){1'b0}}, rs1 < opb};
            3'b100: result = rs1 ^ opb;
            3'b101: begin
                if (decoded.alt)
                    result = $signed(rs1) >>> shamt;
                else
                    result = rs1 >> shamt;
            end
            3'b110: result = rs1 | opb;
            default: result = rs1 & opb;
        endcase
    end

    always_comb begin
        case (decoded.funct3)
            3'b000: branch_taken = rs1 == rs2;
            3'b001: branch_taken = rs1 != rs2;
            3'b100: branch_taken = $signed(rs1) < $signed(rs2);
            3'b101: branch_taken = $signed(rs1) >= $signed(rs2);
            3'b110: branch_taken = rs1 < rs2;
            3'b111: branch_taken = rs1 >= rs2;
            default: branch_taken = 1'b0;
        endcase
    end

    // In immediate form only the shift funct7 field reaches bit 30
    always_comb begin
        if (decoded.use_imm)
            alt_bad = decoded.funct3 == 3'b001;
        else
            alt_bad = decoded.funct3 != 3'b000 && decoded.funct3 != 3'b101;
    end

    assign illegal = (decoded.op_class == ALU) && decoded.alt && alt_bad;

endmodule

`default_nettype wire

// File: logic/exec_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module exec_multiplier #(
    parameter int WIDTH = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    iter_op_if.unit op
);
    localparam int CNT_W = $clog2(WIDTH + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(WIDTH);

    logic               busy;
    logic               done;
    logic [CNT_W-1:0]   step;
    logic [2*WIDTH-1:0] mcand;
    logic [WIDTH-1:0]   mplier;
    logic [2*WIDTH-1:0] acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (op.req_valid && !busy) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                if (step == LAST) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // One partial product per cycle
    always_ff @(posedge clk) begin
        if (op.req_valid && !busy) begin
            mcand  <= {{WIDTH{1'b0}}, op.operand_a};
            mplier <= op.operand_b;
            acc    <= '0;
        end else if (busy && step != LAST) begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign op.req_ready  = !busy;
    assign op.resp_valid = done;
    assign op.result     = acc;

endmodule

`default_nettype wire

// File: logic/exec_divider.sv
`timescale 1ns/1ps
`default_nettype none

module exec_divider #(
    parameter int WIDTH = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    iter_op_if.unit op
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(WIDTH + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(WIDTH);

    logic             busy;
    logic             done;
    logic [CNT_W-1:0] step;
    logic [WIDTH-1:0] divisor;
    logic [WIDTH-1:0] quo;
    logic [WIDTH-1:0] rem;
    logic             by_zero;
    logic [WIDTH:0]   partial;
    logic [WIDTH:0]   diff;
    div_result_t      res;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (op.req_valid && !busy) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                if (step == LAST) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // Next dividend bit enters the partial remainder
    assign partial = {rem, quo[WIDTH-1]};
    assign diff    = partial - {1'b0, divisor};

    // Zero divisor never borrows, so quotient fills with ones
    always_ff @(posedge clk) begin
        if (op.req_valid && !busy) begin
            divisor <= op.operand_b;
            quo     <= op.operand_a;
            rem     <= '0;
            by_zero <= op.operand_b == '0;
        end else if (busy && step != LAST) begin
            if (!diff[WIDTH]) begin
                rem <= diff[WIDTH-1:0];
                quo <= {quo[WIDTH-2:0], 1'b1};
            end else begin
                rem <= partial[WIDTH-1:0];
                quo <= {quo[WIDTH-2:0], 1'b0};
            end
        end
    end

    always_comb begin
        res.quotient  = quo;
        res.remainder = rem;
        res.by_zero   = by_zero;
    end

    assign op.req_ready  = !busy;
    assign op.resp_valid = done;
    assign op.result     = res;

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [exec_pkg::XLEN-1:0] in_instr,
    input  logic [exec_pkg::XLEN-1:0] in_pc,
    input  logic [exec_pkg::XLEN-1:0] in_rs1,
    input  logic [exec_pkg::XLEN-1:0] in_rs2,

    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [4:0]                out_rd,
    output logic                      out_rd_write,
    output logic [exec_pkg::XLEN-1:0] out_rd_wdata,
    output logic                      out_branch_taken,
    output logic [exec_pkg::XLEN-1:0] out_branch_target,
    output logic                      out_illegal
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_UNIT,
        S_HOLD_OUT
    } state_e;

    state_e          state;
    logic            req_sent;
    logic [XLEN-1:0] instr_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] unit_q;

    decoded_t        dec;
    logic [XLEN-1:0] alu_result;
    logic            alu_branch;
    logic            alu_illegal;
    logic            illegal;

    logic            is_mul;
    logic            is_div;
    logic            a_signed;
    logic            b_signed;
    logic            neg_a;
    logic            neg_b;
    logic            prod_inv;
    logic [XLEN-1:0] mag_a;
    logic [XLEN-1:0] mag_b;
    mul_result_t     prod_fix;
    div_result_t     div_res;
    logic [XLEN-1:0] mul_word;
    logic [XLEN-1:0] div_word;
    logic            req_fire;
    logic            resp_fire;

    iter_op_if #(.WIDTH(XLEN), .result_t(mul_result_t)) mul_if ();
    iter_op_if #(.WIDTH(XLEN), .result_t(div_result_t)) div_if ();

    exec_decoder decoder_i (
        .instr   (instr_q),
        .decoded (dec)
    );

    exec_alu alu_i (
        .decoded      (dec),
        .rs1          (rs1_q),
        .rs2          (rs2_q),
        .result       (alu_result),
        .branch_taken (alu_branch),
        .illegal      (alu_illegal)
    );

    exec_multiplier #(.WIDTH(XLEN)) multiplier_i (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (mul_if.unit)
    );

    exec_divider #(.WIDTH(XLEN)) divider_i (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (div_if.unit)
    );

    assign is_mul = dec.op_class == MUL;
    assign is_div = dec.op_class == DIV;

    // MULHSU signs rs1 only and the unsigned forms sign neither operand
    always_comb begin
        if (is_div) begin
            a_signed = !dec.funct3[0];
            b_signed = !dec.funct3[0];
        end else begin
            a_signed = dec.funct3[1:0] != 2'b11;
            b_signed = !dec.funct3[1];
        end
    end

    assign neg_a    = a_signed && rs1_q[XLEN-1];
    assign neg_b    = b_signed && rs2_q[XLEN-1];
    assign prod_inv = neg_a ^ neg_b;
    assign mag_a    = neg_a ? -rs1_q : rs1_q;
    assign mag_b    = neg_b ? -rs2_q : rs2_q;

    assign mul_if.operand_a = mag_a;
    assign mul_if.operand_b = mag_b;
    assign div_if.operand_a = mag_a;
    assign div_if.operand_b = mag_b;
    assign mul_if.req_valid = (state == S_WAIT_UNIT) && !req_sent && is_mul;
    assign div_if.req_valid = (state == S_WAIT_UNIT) && !req_sent && is_div;

    assign req_fire  = (mul_if.req_valid && mul_if.req_ready) ||
                       (div_if.req_valid && div_if.req_ready);
    assign resp_fire = req_sent && (is_mul ? mul_if.resp_valid : div_if.resp_valid);

    assign prod_fix = prod_inv ? -mul_if.result : mul_if.result;
    assign mul_word = (dec.funct3[1:0] == 2'b00) ? prod_fix[XLEN-1:0] : prod_fix[2*XLEN-1:XLEN];
    assign div_res  = div_if.result;

    // Divide by zero bypasses the sign correction
    always_comb begin
        if (div_res.by_zero)
            div_word = dec.funct3[1] ? rs1_q : '1;
        else if (dec.funct3[1])
            div_word = neg_a ? -div_res.remainder : div_res.remainder;
        else
            div_word = prod_inv ? -div_res.quotient : div_res.quotient;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            req_sent <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    req_sent <= 1'b0;
                    if (in_valid)
                        state <= S_WAIT_UNIT;
                end
                S_WAIT_UNIT: begin
                    if (req_fire)
                        req_sent <= 1'b1;
                    if ((!is_mul && !is_div) || resp_fire)
                        state <= S_HOLD_OUT;
                end
                default: begin
                    if (out_ready)
                        state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && in_valid) begin
            instr_q <= in_instr;
            pc_q    <= in_pc;
            rs1_q   <= in_rs1;
            rs2_q   <= in_rs2;
        end
        if (state == S_WAIT_UNIT && resp_fire)
            unit_q <= is_mul ? mul_word : div_word;
    end

    always_comb begin
        case (dec.op_class)
            LUI:       out_rd_wdata = dec.imm;
            AUIPC:     out_rd_wdata = pc_q + dec.imm;
            JAL, JALR: out_rd_wdata = pc_q + 32'd4;
            MUL, DIV:  out_rd_wdata = unit_q;
            default:   out_rd_wdata = alu_result;
        endcase
    end

    assign illegal           = dec.illegal || alu_illegal;
    assign out_illegal       = illegal;
    assign out_rd            = dec.rd;
    assign out_rd_write      = dec.rd_write && !illegal;
    assign out_branch_target = (dec.op_class == JALR) ? ((rs1_q + dec.imm) & ~32'd1) :
                               (pc_q + dec.imm);
    assign out_branch_taken  = !illegal && ((dec.op_class == JAL) || (dec.op_class == JALR) ||
                               ((dec.op_class == BRANCH) && alu_branch));

    assign in_ready  = state == S_IDLE;
    assign out_valid = state == S_HOLD_OUT;

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// File: sim/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb;
    import exec_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic [31:0] in_rs1;
    logic [31:0] in_rs2;
    logic        out_valid;
    logic        out_ready;
    logic [4:0]  out_rd;
    logic        out_rd_write;
    logic [31:0] out_rd_wdata;
    logic        out_branch_taken;
    logic [31:0] out_branch_target;
    logic        out_illegal;

    logic [31:0] lcg_state = 32'd98;

    // Expected record of the instruction in flight
    logic        exp_illegal;
    logic [4:0]  exp_rd;
    logic        exp_write;
    logic [31:0] exp_wdata;
    logic        exp_taken;
    logic [31:0] exp_target;
    logic        exp_has_target;

    tb_clock #(.PERIOD_NS(4.0)) clock_i (.clk(clk));

    exec_stage exec_stage_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .in_instr          (in_instr),
        .in_pc             (in_pc),
        .in_rs1            (in_rs1),
        .in_rs2            (in_rs2),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .out_rd            (out_rd),
        .out_rd_write      (out_rd_write),
        .out_rd_wdata      (out_rd_wdata),
        .out_branch_taken  (out_branch_taken),
        .out_branch_target (out_branch_target),
        .out_illegal       (out_illegal)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // Swap halves since the low LCG bits repeat quickly
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        logic [31:0] pick;
        r = next_rand();
        pick = next_rand();
        case (pick[2:0])
            3'd0: return 32'h0000_0000;
            3'd1: return 32'h8000_0000;
            3'd2: return 32'hffff_ffff;
            3'd3: return 32'h7fff_ffff;
            default: return r;
        endcase
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = next_rand();
        return r & ~32'd3;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? x - y : x + y;
            3'd1: res = x << y[4:0];
            3'd2: res = {31'd0, $signed(x) < $signed(y)};
            3'd3: res = {31'd0, x < y};
            3'd4: res = x ^ y;
            3'd5: begin
                if (alt)
                    res = $signed(x) >>> y[4:0];
                else
                    res = x >> y[4:0];
            end
            3'd6: res = x | y;
            default: res = x & y;
        endcase
        return res;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
        case (f3)
            3'd0: return x == y;
            3'd1: return x != y;
            3'd4: return $signed(x) < $signed(y);
            3'd5: return $signed(x) >= $signed(y);
            3'd6: return x < y;
            default: return x >= y;
        endcase
    endfunction

    function automatic logic [31:0] muldiv_ref(input logic [2:0] f3, input logic [31:0] x,
                                               input logic [31:0] y);
        logic [63:0] sx;
        logic [63:0] sy;
        logic [63:0] ux;
        logic [63:0] uy;
        logic [63:0] p;
        logic [31:0] res;
        logic        ovf;
        sx = {{32{x[31]}}, x};
        sy = {{32{y[31]}}, y};
        ux = {32'd0, x};
        uy = {32'd0, y};
        p = 64'd0;
        ovf = (x == 32'h8000_0000) && (y == 32'hffff_ffff);
        case (f3)
            3'd0: p = sx * sy;
            3'd1: p = sx * sy;
            3'd2: p = sx * uy;
            3'd3: p = ux * uy;
            default: p = 64'd0;
        endcase
        res = (f3 == 3'd0) ? p[31:0] : p[63:32];
        if (f3 == 3'd4 || f3 == 3'd5) begin
            if (y == 32'd0)
                res = 32'hffff_ffff;
            else if (f3 == 3'd5)
                res = x / y;
            else if (ovf)
                res = x;
            else
                res = $signed(x) / $signed(y);
        end else if (f3 == 3'd6 || f3 == 3'd7) begin
            if (y == 32'd0)
                res = x;
            else if (f3 == 3'd7)
                res = x % y;
            else if (ovf)
                res = 32'd0;
            else
                res = $signed(x) % $signed(y);
        end
        return res;
    endfunction

    // RV32IM rules for the expected output record
    task automatic predict(input logic [31:0] instr, input logic [31:0] pc,
                           input logic [31:0] a, input logic [31:0] b);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] imm_b;
        logic        writes;
        f3 = instr[14:12];
        f7 = instr[31:25];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_u = {instr[31:12], 12'h000};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        exp_illegal = 1'b0;
        writes = 1'b1;
        exp_wdata = 32'd0;
        exp_taken = 1'b0;
        exp_target = 32'd0;
        exp_has_target = 1'b0;
        case (instr[6:0])
            OPCODE_OP: begin
                if (f7 == 7'h01)
                    exp_wdata = muldiv_ref(f3, a, b);
                else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                    exp_wdata = alu_ref(f3, f7[5], a, b);
                else
                    exp_illegal = 1'b1;
            end
            OPCODE_OP_IMM: begin
                if (f3 == 3'd1 && instr[30])
                    exp_illegal = 1'b1;
                else
                    exp_wdata = alu_ref(f3, f3 == 3'd5 && instr[30], a, imm_i);
            end
            OPCODE_LUI: exp_wdata = imm_u;
            OPCODE_AUIPC: exp_wdata = pc + imm_u;
            OPCODE_JAL: begin
                exp_wdata = pc + 32'd4;
                exp_taken = 1'b1;
                exp_target = pc + imm_j;
                exp_has_target = 1'b1;
            end
            OPCODE_JALR: begin
                if (f3 != 3'd0) begin
                    exp_illegal = 1'b1;
                end else begin
                    exp_wdata = pc + 32'd4;
                    exp_taken = 1'b1;
                    exp_target = (a + imm_i) & ~32'd1;
                    exp_has_target = 1'b1;
                end
            end
            OPCODE_BRANCH: begin
                writes = 1'b0;
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    exp_illegal = 1'b1;
                end else begin
                    exp_taken = branch_ref(f3, a, b);
                    exp_target = pc + imm_b;
                    exp_has_target = 1'b1;
                end
            end
            default: exp_illegal = 1'b1;
        endcase
        exp_rd = instr[11:7];
        exp_write = writes && !exp_illegal && (exp_rd != 5'd0);
    endtask

    task automatic compare_field(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout: %s did not happen within 200 cycles at %0d ns", what, $time);
        $display("TB FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send(input logic [31:0] instr, input logic [31:0] pc,
                        input logic [31:0] a, input logic [31:0] b);
        int waited;
        in_instr = instr;
        in_pc = pc;
        in_rs1 = a;
        in_rs2 = b;
        in_valid = 1'b1;
        waited = 0;
        while (!in_ready) begin
            step_cycle();
            waited++;
            if (waited > 200)
                fail_timeout("in_ready");
        end
        step_cycle();
        in_valid = 1'b0;
    endtask

    task automatic check_expected();
        compare_field("out_illegal", 32'(out_illegal), 32'(exp_illegal));
        compare_field("out_rd", 32'(out_rd), 32'(exp_rd));
        compare_field("out_rd_write", 32'(out_rd_write), 32'(exp_write));
        compare_field("out_branch_taken", 32'(out_branch_taken), 32'(exp_taken));
        if (exp_write)
            compare_field("out_rd_wdata", out_rd_wdata, exp_wdata);
        if (exp_has_target)
            compare_field("out_branch_target", out_branch_target, exp_target);
    endtask

    // Stalled output must not move
    task automatic check_held(input logic [71:0] held);
        compare_field("out_valid", 32'(out_valid), 32'd1);
        compare_field("in_ready", 32'(in_ready), 32'd0);
        compare_field("out_rd", 32'(out_rd), 32'(held[71:67]));
        compare_field("out_rd_write", 32'(out_rd_write), 32'(held[66]));
        compare_field("out_rd_wdata", out_rd_wdata, held[65:34]);
        compare_field("out_branch_taken", 32'(out_branch_taken), 32'(held[33]));
        compare_field("out_branch_target", out_branch_target, held[32:1]);
        compare_field("out_illegal", 32'(out_illegal), 32'(held[0]));
    endtask

    task automatic collect();
        int          waited;
        logic [31:0] r;
        logic        stalled;
        logic [71:0] held;
        out_ready = 1'b0;
        waited = 0;
        while (!out_valid) begin
            step_cycle();
            waited++;
            if (waited > 200)
                fail_timeout("out_valid");
        end
        check_expected();
        held = {out_rd, out_rd_write, out_rd_wdata, out_branch_taken,
                out_branch_target, out_illegal};
        stalled = 1'b1;
        waited = 0;
        while (stalled) begin
            r = next_rand();
            out_ready = r[1:0] != 2'b00;
            stalled = !out_ready;
            step_cycle();
            if (stalled) begin
                check_held(held);
                waited++;
                if (waited > 200)
                    fail_timeout("output transfer");
            end
        end
        out_ready = 1'b0;
        compare_field("out_valid", 32'(out_valid), 32'd0);
    endtask

    task automatic run_instr(input logic [31:0] instr, input logic [31:0] pc,
                             input logic [31:0] a, input logic [31:0] b);
        predict(instr, pc, a, b);
        send(instr, pc, a, b);
        collect();
    endtask

    initial begin
        int          i;
        logic [31:0] w;
        logic [31:0] a;
        logic [2:0]  f3;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_instr = 32'd0;
        in_pc = 32'd0;
        in_rs1 = 32'd0;
        in_rs2 = 32'd0;
        out_ready = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        compare_field("in_ready", 32'(in_ready), 32'd1);
        compare_field("out_valid", 32'(out_valid), 32'd0);

        // Register and immediate ALU forms with some rd = x0
        for (i = 0; i < 160; i++) begin
            w = next_rand();
            f3 = w[14:12];
            if (i % 2 == 0) begin
                w[6:0] = OPCODE_OP;
                w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[25]) ? 7'h20 : 7'h00;
            end else begin
                w[6:0] = OPCODE_OP_IMM;
                if (f3 == 3'd1)
                    w[31:25] = 7'h00;
                else if (f3 == 3'd5)
                    w[31:25] = w[25] ? 7'h20 : 7'h00;
            end
            if (i % 8 < 2)
                w[11:7] = 5'd0;
            run_instr(w, rand_pc(), rand_operand(), rand_operand());
        end

        for (i = 0; i < 48; i++) begin
            w = next_rand();
            case (i % 4)
                0: w[6:0] = OPCODE_LUI;
                1: w[6:0] = OPCODE_AUIPC;
                2: w[6:0] = OPCODE_JAL;
                default: begin
                    w[6:0] = OPCODE_JALR;
                    w[14:12] = 3'b000;
                end
            endcase
            run_instr(w, rand_pc(), rand_operand(), rand_operand());
        end

        // Every third round of six branches compares equal operands
        for (i = 0; i < 72; i++) begin
            w = next_rand();
            w[6:0] = OPCODE_BRANCH;
            w[14:12] = (i % 6 < 2) ? 3'(i % 6) : 3'(i % 6 + 2);
            a = rand_operand();
            run_instr(w, rand_pc(), a, ((i / 6) % 3 == 0) ? a : rand_operand());
        end

        for (i = 0; i < 96; i++) begin
            w = next_rand();
            w[6:0] = OPCODE_OP;
            w[31:25] = FUNCT7_MULDIV;
            run_instr(w, rand_pc(), rand_operand(), rand_operand());
        end

        // Signed overflow and zero divisor on every M operation
        for (i = 0; i < 8; i++) begin
            w = next_rand();
            w[6:0] = OPCODE_OP;
            w[31:25] = FUNCT7_MULDIV;
            w[14:12] = 3'(i);
            run_instr(w, rand_pc(), 32'h8000_0000, 32'hffff_ffff);
            run_instr(w, rand_pc(), rand_operand(), 32'd0);
        end

        for (i = 0; i < 30; i++) begin
            w = next_rand();
            case (i % 6)
                0: w[6:0] = 7'b0000011;
                1: w[6:0] = 7'b1110011;
                2: begin
                    w[6:0] = OPCODE_JALR;
                    w[12] = 1'b1;
                end
                3: begin
                    // SLLI with the SUB bit set
                    w[6:0] = OPCODE_OP_IMM;
                    w[14:12] = 3'b001;
                    w[31:25] = 7'h20;
                end
                4: begin
                    w[6:0] = OPCODE_BRANCH;
                    w[14:13] = 2'b01;
                end
                default: begin
                    w[6:0] = OPCODE_OP;
                    w[31:25] = 7'h40;
                end
            endcase
            run_instr(w, rand_pc(), rand_operand(), rand_operand());
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_stage.f
logic/exec_pkg.sv
logic/iter_op_if.sv
logic/exec_decoder.sv
logic/exec_alu.sv
logic/exec_multiplier.sv
logic/exec_divider.sv
logic/exec_stage.sv
sim/tb_clock.sv
sim/exec_stage_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module exec_stage_tb \
    -f exec_stage.f -Mdir obj_dir -o exec_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/exec_stage_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TB PASSED$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
